// ==== files.f ====
qual_pkg.sv
qual_ctrl_if.sv
delay_line.sv
floor_compare.sv
ceiling_compare.sv
lane_combine.sv
qual_ctrl.sv
lane_qual_top.sv
qual_checker.sv
tb_lane_qual.sv

// ==== tb_lane_qual.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_lane_qual;
  import qual_pkg::*;

  localparam int NUM_ROWS   = 16;
  localparam int BURST_ROWS = 5;
  localparam int SEED       = 82428;
  localparam int MAX_CYCLES = NUM_ROWS * 20 + 200;

  logic        clk;
  logic        rst_n;
  word_t       i_data;
  logic        i_valid;
  logic        o_ready;
  word_t       o_data;
  logic        o_valid;
  logic        i_out_ready;
  logic        i_cfg_valid;
  lane_fmt_e   i_cfg_fmt;
  sample_t     i_cfg_lo;
  sample_t     i_cfg_hi;
  logic        o_cfg_ready;
  logic        bp_on;
  logic        bp_now;
  logic        finish;
  int          pass_cnt;
  int          fail_cnt;
  int          pending;
  int          n_rows;

  // Stimulus table
  lane_fmt_e row_fmt  [NUM_ROWS];
  sample_t   row_lo   [NUM_ROWS];
  sample_t   row_hi   [NUM_ROWS];
  word_t     row_data [NUM_ROWS];

  lane_qual_top #(.FLOOR_LAT(2), .CEIL_LAT(1)) uut (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_data      (i_data),
    .i_valid     (i_valid),
    .o_ready     (o_ready),
    .o_data      (o_data),
    .o_valid     (o_valid),
    .i_out_ready (i_out_ready),
    .i_cfg_valid (i_cfg_valid),
    .i_cfg_fmt   (i_cfg_fmt),
    .i_cfg_lo    (i_cfg_lo),
    .i_cfg_hi    (i_cfg_hi),
    .o_cfg_ready (o_cfg_ready)
  );

  qual_checker u_check (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_in_data   (i_data),
    .i_in_valid  (i_valid),
    .i_in_ready  (o_ready),
    .i_out_data  (o_data),
    .i_out_valid (o_valid),
    .i_out_ready (i_out_ready),
    .i_cfg_valid (i_cfg_valid),
    .i_cfg_fmt   (i_cfg_fmt),
    .i_cfg_lo    (i_cfg_lo),
    .i_cfg_hi    (i_cfg_hi),
    .i_cfg_ready (o_cfg_ready),
    .i_finish    (finish),
    .o_pass_cnt  (pass_cnt),
    .o_fail_cnt  (fail_cnt),
    .o_pending   (pending)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic add_row(input lane_fmt_e f, input sample_t lo, input sample_t hi,
                         input word_t w);
    row_fmt[n_rows]  = f;
    row_lo[n_rows]   = lo;
    row_hi[n_rows]   = hi;
    row_data[n_rows] = w;
    n_rows++;
  endtask

  task automatic configure(input lane_fmt_e f, input sample_t lo, input sample_t hi);
    i_valid     = 1'b0;
    i_cfg_fmt   = f;
    i_cfg_lo    = lo;
    i_cfg_hi    = hi;
    i_cfg_valid = 1'b1;
    do begin
      @(negedge clk);
    end while (!o_cfg_ready);
    @(posedge clk);
    #1;
    i_cfg_valid = 1'b0;
  endtask

  task automatic send_beat(input word_t w);
    i_data  = w;
    i_valid = 1'b1;
    do begin
      @(negedge clk);
    end while (!o_ready);
    @(posedge clk);
    #1;
    i_valid = 1'b0;
  endtask

  // Downstream ready goes random once the burst is over
  initial begin
    forever begin
      @(negedge clk);
      bp_now = bp_on;
      @(posedge clk);
      #1;
      i_out_ready = bp_now ? ($urandom % 3 != 0) : 1'b1;
    end
  end

  initial begin
    repeat (MAX_CYCLES) @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
    $display("Result: FAILED");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    lane_fmt_e cur_fmt;
    sample_t   cur_lo;
    sample_t   cur_hi;
    void'($urandom(SEED));
    rst_n       = 1'b0;
    i_data      = '0;
    i_valid     = 1'b0;
    i_out_ready = 1'b1;
    i_cfg_valid = 1'b0;
    i_cfg_fmt   = FMT_REAL;
    i_cfg_lo    = '0;
    i_cfg_hi    = 16'sh7FFF;
    bp_on       = 1'b0;
    bp_now      = 1'b0;
    finish      = 1'b0;
    n_rows      = 0;
    // Real format with exact thresholds in a back-to-back burst
    add_row(FMT_REAL, 16'sh0100, 16'sh4000, 128'h0100_FF00_4000_C000_00FF_FF01_4001_8000);
    add_row(FMT_REAL, 16'sh0100, 16'sh4000, 128'h1234_EDCC_0000_7FFF_0200_FE00_3FFF_C001);
    add_row(FMT_REAL, 16'sh0100, 16'sh4000, 128'h0101_0000_8001_2000_E000_00FF_0F0F_F0F0);
    add_row(FMT_REAL, 16'sh0100, 16'sh4000, 128'h4000_BFFF_0100_FF00_1111_EEEF_0A0A_F5F6);
    add_row(FMT_REAL, 16'sh0100, 16'sh4000, 128'h0001_FFFF_2222_DDDE_3000_D000_0180_FE80);
    // Most negative sample against full-scale limits
    add_row(FMT_REAL, 16'sh0000, 16'sh7FFF, 128'h8000_7FFF_0000_FFFF_8001_1234_ABCD_0001);
    add_row(FMT_REAL, 16'sh7FFF, 16'sh7FFF, 128'h8000_7FFF_8001_7FFE_0000_8002_1000_7FFF);
    // Complex pairs
    add_row(FMT_CPLX, 16'sh0080, 16'sh1000, 128'h0080_F000_0100_1001_0000_0500_FF80_EFFF);
    add_row(FMT_CPLX, 16'sh0080, 16'sh1000, 128'h0FFF_F001_007F_0200_FF81_0C00_1000_F000);
    add_row(FMT_CPLX, 16'sh0080, 16'sh1000, 128'h0400_0400_8000_0400_0800_F800_0081_FF7F);
    // Wide groups of four
    add_row(FMT_WIDE, 16'sh0010, 16'sh2000, 128'h0010_FFF0_2000_E000_0010_000F_0100_0100);
    add_row(FMT_WIDE, 16'sh0010, 16'sh2000, 128'h1000_F000_0800_F800_2001_0100_0100_0100);
    add_row(FMT_WIDE, 16'sh0010, 16'sh2000, 128'h0020_0030_0040_0050_FFE0_FFD0_FFC0_FFB0);
    add_row(FMT_REAL, 16'sh0200, 16'sh0800, 128'h0200_0800_0801_01FF_FE00_F800_F7FF_FE01);
    add_row(FMT_REAL, 16'sh0200, 16'sh0800, 128'h0400_FC00_0600_FA00_8000_7FFF_0000_0300);
    add_row(FMT_CPLX, 16'sh0000, 16'sh7FFF, 128'h8000_0001_7FFF_8001_0000_0000_1234_5678);
    cur_fmt = FMT_REAL;
    cur_lo  = '0;
    cur_hi  = 16'sh7FFF;
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
    for (int r = 0; r < NUM_ROWS; r++) begin
      if (row_fmt[r] != cur_fmt || row_lo[r] != cur_lo || row_hi[r] != cur_hi) begin
        configure(row_fmt[r], row_lo[r], row_hi[r]);
        cur_fmt = row_fmt[r];
        cur_lo  = row_lo[r];
        cur_hi  = row_hi[r];
      end
      bp_on = (r >= BURST_ROWS);
      send_beat(row_data[r]);
    end
    // Wait for the pipeline to empty and then look for stray beats
    do begin
      @(posedge clk);
    end while (pending != 0);
    repeat (6) @(posedge clk);
    finish = 1'b1;
    repeat (2) @(posedge clk);
    if (pass_cnt != NUM_ROWS) begin
      $display("Only %0d of %0d beats came out and matched", pass_cnt, NUM_ROWS);
    end
    $display("Summary: %0d beats sent, %0d passed, %0d failures", NUM_ROWS, pass_cnt, fail_cnt);
    if (fail_cnt == 0 && pass_cnt == NUM_ROWS) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== qual_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module qual_checker (
  input  wire                       clk,
  input  wire                       rst_n,
  input  wire qual_pkg::word_t      i_in_data,
  input  wire                       i_in_valid,
  input  wire                       i_in_ready,
  input  wire qual_pkg::word_t      i_out_data,
  input  wire                       i_out_valid,
  input  wire                       i_out_ready,
  input  wire                       i_cfg_valid,
  input  wire qual_pkg::lane_fmt_e  i_cfg_fmt,
  input  wire qual_pkg::sample_t    i_cfg_lo,
  input  wire qual_pkg::sample_t    i_cfg_hi,
  input  wire                       i_cfg_ready,
  input  wire                       i_finish,
  output int                        o_pass_cnt,
  output int                        o_fail_cnt,
  output int                        o_pending
);
  import qual_pkg::*;

  // Register loads from acceptance to the output word
  localparam int PIPE_STAGES = 3;

  word_t     exp_q [$];
  int        tag_q [$];
  lane_fmt_e fmt;
  sample_t   lo;
  sample_t   hi;
  int        moves;
  int        beat;
  logic      adv;
  logic      shown;
  logic      held;
  logic      finished;
  logic      started;
  word_t     held_data;

  // Magnitude of one sample with the most negative value clipped to full scale
  function automatic int magnitude(sample_t s);
    int v;
    v = s;
    if (v < 0) v = -v;
    if (v > 32767) v = 32767;
    return v;
  endfunction

  // Keep an element only if every sample lies inside [lo, hi]
  function automatic word_t expect_word(word_t w, lane_fmt_e f, sample_t lo_t, sample_t hi_t);
    int    grp;
    int    m;
    logic  ok;
    word_t r;
    grp = (f == FMT_CPLX) ? 2 : (f == FMT_WIDE) ? 4 : 1;
    r = '0;
    for (int e = 0; e < NUM_LANES; e += grp) begin
      ok = 1'b1;
      for (int k = 0; k < grp; k++) begin
        m = magnitude(w[(e+k)*SAMPLE_W +: SAMPLE_W]);
        if (m < lo_t || m > hi_t) ok = 1'b0;
      end
      for (int k = 0; k < grp; k++) begin
        if (ok) r[(e+k)*SAMPLE_W +: SAMPLE_W] = w[(e+k)*SAMPLE_W +: SAMPLE_W];
      end
    end
    return r;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Port monitor sampled mid-cycle
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    if (!rst_n) begin
      fmt = FMT_REAL;
      lo = '0;
      hi = 16'sh7FFF;
      moves = 0;
      beat = 0;
      shown = 1'b0;
      held = 1'b0;
      finished = 1'b0;
      started = 1'b0;
      o_pass_cnt = 0;
      o_fail_cnt = 0;
      o_pending = 0;
      exp_q.delete();
      tag_q.delete();
    end else begin
      // Handshake outputs stay low until the first edge after reset
      if (!started) begin
        started = 1'b1;
        if (i_in_ready || i_out_valid || i_cfg_ready) begin
          $display("FAIL first cycle after reset: o_ready %h, o_valid %h, o_cfg_ready %h",
                   i_in_ready, i_out_valid, i_cfg_ready);
          o_fail_cnt++;
        end
      end
      adv = !i_out_valid || i_out_ready;
      // A stalled word must not move
      if (held && (!i_out_valid || i_out_data !== held_data)) begin
        $display("FAIL o_data changed while stalled: held %h, now %h", held_data, i_out_data);
        o_fail_cnt++;
      end
      held = i_out_valid && !i_out_ready;
      held_data = i_out_data;
      if (i_cfg_ready && (exp_q.size() != 0 || i_out_valid)) begin
        $display("FAIL o_cfg_ready: expected 0, actual %h with %0d beats still in flight",
                 i_cfg_ready, exp_q.size());
        o_fail_cnt++;
      end
      if (i_out_valid && !shown) begin
        shown = 1'b1;
        if (exp_q.size() == 0) begin
          $display("An output beat appeared that no accepted input accounts for");
          o_fail_cnt++;
        end else begin
          beat++;
          if (i_out_data !== exp_q[0]) begin
            $display("FAIL o_data beat %0d: expected %h, actual %h", beat, exp_q[0], i_out_data);
            o_fail_cnt++;
          end else if (moves - tag_q[0] != PIPE_STAGES) begin
            $display("Beat %0d came out after %0d pipeline steps instead of %0d",
                     beat, moves - tag_q[0], PIPE_STAGES);
            o_fail_cnt++;
          end else begin
            $display("ok beat %0d: o_data %h", beat, i_out_data);
            o_pass_cnt++;
          end
        end
      end
      if (i_out_valid && i_out_ready) begin
        shown = 1'b0;
        if (exp_q.size() != 0) begin
          void'(exp_q.pop_front());
          void'(tag_q.pop_front());
        end
      end
      // Judged with the settings that are active when the beat enters
      if (i_in_valid && i_in_ready) begin
        exp_q.push_back(expect_word(i_in_data, fmt, lo, hi));
        tag_q.push_back(moves);
      end
      if (adv) moves++;
      if (i_cfg_valid && i_cfg_ready) begin
        fmt = i_cfg_fmt;
        lo = i_cfg_lo;
        hi = i_cfg_hi;
      end
      if (i_finish && !finished) begin
        finished = 1'b1;
        if (exp_q.size() != 0) begin
          $display("%0d expected beats never came out of the DUT", exp_q.size());
          o_fail_cnt++;
        end
      end
      o_pending = exp_q.size();
    end
  end

endmodule

`default_nettype wire

// ==== lane_qual_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module lane_qual_top #(
  parameter int FLOOR_LAT = 2,
  parameter int CEIL_LAT  = 1
) (
  input  wire                       clk,
  input  wire                       rst_n,
  input  wire qual_pkg::word_t      i_data,
  input  wire                       i_valid,
  output logic                      o_ready,
  output qual_pkg::word_t           o_data,
  output logic                      o_valid,
  input  wire                       i_out_ready,
  input  wire                       i_cfg_valid,
  input  wire qual_pkg::lane_fmt_e  i_cfg_fmt,
  input  wire qual_pkg::sample_t    i_cfg_lo,
  input  wire qual_pkg::sample_t    i_cfg_hi,
  output logic                      o_cfg_ready
);
  import qual_pkg::*;

  // Ceiling mask waits for the slower floor result
  localparam int MASK_DLY = FLOOR_LAT - CEIL_LAT;

  lane_mask_t floor_mask;
  lane_mask_t ceil_mask;
  lane_mask_t ceil_mask_al;
  word_t      data_al;

  qual_ctrl_if ctrl_bus ();

  qual_ctrl u_ctrl (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_valid     (i_valid),
    .i_out_ready (i_out_ready),
    .i_cfg_valid (i_cfg_valid),
    .i_cfg_fmt   (i_cfg_fmt),
    .i_cfg_lo    (i_cfg_lo),
    .i_cfg_hi    (i_cfg_hi),
    .o_ready     (o_ready),
    .o_valid     (o_valid),
    .o_cfg_ready (o_cfg_ready),
    .ctrl        (ctrl_bus.ctrl)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Compare units and alignment
  ////////////////////////////////////////////////////////////////////////////

  floor_compare #(.LAT(FLOOR_LAT)) u_floor (
    .clk    (clk),
    .rst_n  (rst_n),
    .ctrl   (ctrl_bus.dp),
    .i_word (i_data),
    .o_mask (floor_mask)
  );

  ceiling_compare #(.LAT(CEIL_LAT)) u_ceil (
    .clk    (clk),
    .rst_n  (rst_n),
    .ctrl   (ctrl_bus.dp),
    .i_word (i_data),
    .o_mask (ceil_mask)
  );

  delay_line #(.DEPTH(MASK_DLY), .WIDTH(NUM_LANES)) u_ceil_dly (
    .clk   (clk),
    .rst_n (rst_n),
    .ctrl  (ctrl_bus.dp),
    .i_d   (ceil_mask),
    .o_q   (ceil_mask_al)
  );

  delay_line #(.DEPTH(FLOOR_LAT), .WIDTH($bits(word_t))) u_data_dly (
    .clk   (clk),
    .rst_n (rst_n),
    .ctrl  (ctrl_bus.dp),
    .i_d   (i_data),
    .o_q   (data_al)
  );

  lane_combine u_combine (
    .clk          (clk),
    .rst_n        (rst_n),
    .ctrl         (ctrl_bus.dp),
    .i_word       (data_al),
    .i_floor_mask (floor_mask),
    .i_ceil_mask  (ceil_mask_al),
    .o_word       (o_data)
  );

endmodule

`default_nettype wire

// ==== qual_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module qual_ctrl (
  input  wire                       clk,
  input  wire                       rst_n,
  input  wire                       i_valid,
  input  wire                       i_out_ready,
  input  wire                       i_cfg_valid,
  input  wire qual_pkg::lane_fmt_e  i_cfg_fmt,
  input  wire qual_pkg::sample_t    i_cfg_lo,
  input  wire qual_pkg::sample_t    i_cfg_hi,
  output logic                      o_ready,
  output logic                      o_valid,
  output logic                      o_cfg_ready,
  qual_ctrl_if.ctrl                 ctrl
);
  import qual_pkg::*;

  state_e     state_q;
  state_e     state_d;
  logic [2:0] vld_q;
  logic [2:0] vld_d;
  logic       live_q;
  logic       advance;
  logic       accept;
  logic       cfg_fire;
  lane_fmt_e  fmt_q;
  sample_t    lo_q;
  sample_t    hi_q;

  // Held low for the first cycle out of reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      live_q <= 1'b0;
    end else begin
      live_q <= 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Handshakes and pipeline enable
  ////////////////////////////////////////////////////////////////////////////

  // Pipeline moves unless a full output register is blocked
  assign advance = !vld_q[2] || i_out_ready;

  // Input closes in DRAIN and while a config request waits
  assign o_ready     = live_q && advance && (state_q != DRAIN) && !i_cfg_valid;
  assign o_cfg_ready = live_q && (state_q == IDLE);
  assign o_valid     = vld_q[2];

  assign accept   = i_valid && o_ready;
  assign cfg_fire = i_cfg_valid && o_cfg_ready;

  // Valid bits follow the data through the three stages
  assign vld_d = advance ? {vld_q[1:0], accept} : vld_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_q <= '0;
    end else begin
      vld_q <= vld_d;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Configuration FSM
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (accept) state_d = RUN;
      end
      RUN: begin
        if (vld_d == '0) begin
          state_d = IDLE;
        end else if (i_cfg_valid) begin
          state_d = DRAIN;
        end
      end
      DRAIN: begin
        if (vld_d == '0) state_d = IDLE;
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
      fmt_q   <= FMT_REAL;
      lo_q    <= '0;
      hi_q    <= 16'sh7FFF;
    end else begin
      state_q <= state_d;
      if (cfg_fire) begin
        fmt_q <= i_cfg_fmt;
        lo_q  <= i_cfg_lo;
        hi_q  <= i_cfg_hi;
      end
    end
  end

  assign ctrl.advance   = advance;
  assign ctrl.fmt       = fmt_q;
  assign ctrl.lo_thresh = lo_q;
  assign ctrl.hi_thresh = hi_q;

endmodule

`default_nettype wire

// ==== lane_combine.sv ====
`timescale 1ns/1ps
`default_nettype none

module lane_combine (
  input  wire                        clk,
  input  wire                        rst_n,
  qual_ctrl_if.dp                    ctrl,
  input  wire qual_pkg::word_t       i_word,
  input  wire qual_pkg::lane_mask_t  i_floor_mask,
  input  wire qual_pkg::lane_mask_t  i_ceil_mask,
  output qual_pkg::word_t            o_word
);
  import qual_pkg::*;

  lane_mask_t keep;

  // A lane survives only if both tests pass
  assign keep = i_floor_mask & i_ceil_mask;

  ////////////////////////////////////////////////////////////////////////////
  // Output register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_word <= '0;
    end else if (ctrl.advance) begin
      for (int i = 0; i < NUM_LANES; i++) begin
        if (keep[i]) begin
          o_word[i*SAMPLE_W +: SAMPLE_W] <= i_word[i*SAMPLE_W +: SAMPLE_W];
        end else begin
          o_word[i*SAMPLE_W +: SAMPLE_W] <= '0;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== ceiling_compare.sv ====
`timescale 1ns/1ps
`default_nettype none

module ceiling_compare #(
  parameter int LAT = 1
) (
  input  wire                   clk,
  input  wire                   rst_n,
  qual_ctrl_if.dp               ctrl,
  input  wire qual_pkg::word_t  i_word,
  output qual_pkg::lane_mask_t  o_mask
);
  import qual_pkg::*;

  lane_mask_t lane_ok;
  lane_mask_t mask_q [LAT];

  // Magnitude and ceiling test in the same cycle
  always_comb begin
    for (int i = 0; i < NUM_LANES; i++) begin
      lane_ok[i] = (sat_abs(sample_t'(i_word[i*SAMPLE_W +: SAMPLE_W])) <= ctrl.hi_thresh);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Registered element mask
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int s = 0; s < LAT; s++) begin
        mask_q[s] <= '0;
      end
    end else if (ctrl.advance) begin
      mask_q[0] <= spread_flags(lane_ok, ctrl.fmt);
      for (int s = 1; s < LAT; s++) begin
        mask_q[s] <= mask_q[s-1];
      end
    end
  end

  assign o_mask = mask_q[LAT-1];

endmodule

`default_nettype wire

// ==== floor_compare.sv ====
`timescale 1ns/1ps
`default_nettype none

module floor_compare #(
  parameter int LAT = 2
) (
  input  wire                   clk,
  input  wire                   rst_n,
  qual_ctrl_if.dp               ctrl,
  input  wire qual_pkg::word_t  i_word,
  output qual_pkg::lane_mask_t  o_mask
);
  import qual_pkg::*;

  sample_t    abs_q [NUM_LANES];
  lane_mask_t lane_ok;
  lane_mask_t mask_q [LAT-1];

  ////////////////////////////////////////////////////////////////////////////
  // Stage 1: per-lane magnitude
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (ctrl.advance) begin
      for (int i = 0; i < NUM_LANES; i++) begin
        abs_q[i] <= sat_abs(sample_t'(i_word[i*SAMPLE_W +: SAMPLE_W]));
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stage 2: floor test and element grouping
  ////////////////////////////////////////////////////////////////////////////

  // Lane passes when its magnitude reaches the floor
  always_comb begin
    for (int i = 0; i < NUM_LANES; i++) begin
      lane_ok[i] = (abs_q[i] >= ctrl.lo_thresh);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int s = 0; s < LAT - 1; s++) begin
        mask_q[s] <= '0;
      end
    end else if (ctrl.advance) begin
      mask_q[0] <= spread_flags(lane_ok, ctrl.fmt);
      // Extra stages only when LAT is above two
      for (int s = 1; s < LAT - 1; s++) begin
        mask_q[s] <= mask_q[s-1];
      end
    end
  end

  assign o_mask = mask_q[LAT-2];

endmodule

`default_nettype wire

// ==== delay_line.sv ====
`timescale 1ns/1ps
`default_nettype none

module delay_line #(
  parameter int DEPTH = 1,
  parameter int WIDTH = 8
) (
  input  wire              clk,
  input  wire              rst_n,
  qual_ctrl_if.dp          ctrl,
  input  wire  [WIDTH-1:0] i_d,
  output logic [WIDTH-1:0] o_q
);

  logic [WIDTH-1:0] stage_q [DEPTH];

  // Shift chain, frozen while the pipeline is stalled
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < DEPTH; i++) begin
        stage_q[i] <= '0;
      end
    end else if (ctrl.advance) begin
      stage_q[0] <= i_d;
      for (int i = 1; i < DEPTH; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  assign o_q = stage_q[DEPTH-1];

endmodule

`default_nettype wire

// ==== qual_ctrl_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface qual_ctrl_if;
  import qual_pkg::*;

  // Shared stage enable
  logic      advance;

  // Active configuration
  lane_fmt_e fmt;
  sample_t   lo_thresh;
  sample_t   hi_thresh;

  modport ctrl (
    output advance,
    output fmt,
    output lo_thresh,
    output hi_thresh
  );

  modport dp (
    input advance,
    input fmt,
    input lo_thresh,
    input hi_thresh
  );

endinterface

`default_nettype wire

// ==== qual_pkg.sv ====
`default_nettype none

package qual_pkg;

  localparam int NUM_LANES = 8;
  localparam int SAMPLE_W  = 16;

  // Element layout of one data word
  typedef enum logic [1:0] {
    FMT_REAL = 2'd0,
    FMT_CPLX = 2'd1,
    FMT_WIDE = 2'd2
  } lane_fmt_e;

  typedef enum logic [1:0] {
    IDLE,
    RUN,
    DRAIN
  } state_e;

  typedef logic signed [SAMPLE_W-1:0]           sample_t;
  typedef logic [NUM_LANES*SAMPLE_W-1:0]        word_t;
  typedef logic [NUM_LANES-1:0]                 lane_mask_t;

  // Absolute value, -32768 clips to 32767
  function automatic sample_t sat_abs(sample_t s);
    sample_t r;
    if (s == {1'b1, {(SAMPLE_W-1){1'b0}}}) begin
      r = {1'b0, {(SAMPLE_W-1){1'b1}}};
    end else if (s < 0) begin
      r = -s;
    end else begin
      r = s;
    end
    return r;
  endfunction

  // AND lane flags across each element and copy the result back to its lanes
  function automatic lane_mask_t spread_flags(lane_mask_t flags, lane_fmt_e fmt);
    lane_mask_t m;
    m = flags;
    case (fmt)
      FMT_CPLX: begin
        for (int e = 0; e < NUM_LANES / 2; e++) begin
          m[2*e +: 2] = {2{&flags[2*e +: 2]}};
        end
      end
      FMT_WIDE: begin
        for (int e = 0; e < NUM_LANES / 4; e++) begin
          m[4*e +: 4] = {4{&flags[4*e +: 4]}};
        end
      end
      default: m = flags;
    endcase
    return m;
  endfunction

endpackage

`default_nettype wire
